// File: src.f
vga_pkg.sv
vga_timing.sv
tile_layer.sv
sprite_layer.sv
pixel_mux.sv
arena_display.sv
tb_checker.sv
tb_arena_display.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the arena renderer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f src.f --top-module tb_arena_display -o sim_arena \
	|| { echo "build failed"; exit 1; }
./obj_dir/sim_arena | tee sim.log
[ -s sim.log ] || { echo "no simulation output"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

// File: tb_arena_display.sv
/*
 * testbench top for the arena renderer
 * clock, reset, stimulus table with one row per frame
 * xorshift arena row, frame loop, timeout, result line
 */

`timescale 1ns/1ps

module tb_arena_display
	import vga_pkg::*;
;

	localparam int H_TOTAL = 800;
	localparam int H_SYNC  = 96;
	localparam int H_START = 144;
	localparam int V_TOTAL = 521;
	localparam int V_SYNC  = 2;
	localparam int V_START = 31;
	localparam int N_ROWS  = 5;
	localparam int FRAME   = H_TOTAL * V_TOTAL;	// 416800 cycles
	localparam int TIMEOUT = (N_ROWS + 2) * FRAME;

	logic pixel_clk, rst;
	grid_bits_t block, bomb_lo, bomb_hi;
	tile_idx_t p1_row, p1_col, p2_row, p2_col;
	game_state_t game;
	logic hsync, vsync;
	rgb_t rgb;
	int exp_p1, exp_p2, errors, frames, pixels, cycles;
	logic [31:0] rng;	// xorshift state

	//////////////////////////////////////////////////////////////////////
	// stimulus table, one row per frame
	//////////////////////////////////////////////////////////////////////

	grid_bits_t  t_block [N_ROWS];
	grid_bits_t  t_lo    [N_ROWS];
	grid_bits_t  t_hi    [N_ROWS];
	tile_idx_t   t_p1r [N_ROWS], t_p1c [N_ROWS], t_p2r [N_ROWS], t_p2c [N_ROWS];
	game_state_t t_game  [N_ROWS];
	int          t_exp1  [N_ROWS], t_exp2 [N_ROWS];	// player pixel counts

	arena_display #(
		.H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC), .H_START(H_START),
		.V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .V_START(V_START)
	) dut0 (
		.pixel_clk(pixel_clk), .rst(rst),
		.block_i(block), .bomb_lo_i(bomb_lo), .bomb_hi_i(bomb_hi),
		.p1_row_i(p1_row), .p1_col_i(p1_col), .p2_row_i(p2_row), .p2_col_i(p2_col),
		.game_i(game),
		.hsync_o(hsync), .vsync_o(vsync), .rgb_o(rgb)
	);

	tb_checker #(
		.H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC), .H_START(H_START),
		.V_SYNC(V_SYNC), .V_START(V_START)
	) checker0 (
		.pixel_clk(pixel_clk), .rst(rst),
		.block_i(block), .bomb_lo_i(bomb_lo), .bomb_hi_i(bomb_hi),
		.p1_row_i(p1_row), .p1_col_i(p1_col), .p2_row_i(p2_row), .p2_col_i(p2_col),
		.game_i(game), .hsync_i(hsync), .vsync_i(vsync), .rgb_i(rgb),
		.exp_p1_i(exp_p1), .exp_p2_i(exp_p2),
		.errors_o(errors), .frames_o(frames), .pixels_o(pixels)
	);

	always #5 pixel_clk = ~pixel_clk;	// 100 MHz stand-in for the pixel clock

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		return v ^ (v << 5);
	endfunction

	function automatic grid_bits_t grid_bit(int r, int c);
		return grid_bits_t'(1) << (r * GRID_N + c);
	endfunction

	task automatic random_grid(output grid_bits_t g);
		logic [31:0] w [4];
		for (int i = 0; i < 4; i++) begin
			rng = xorshift32(rng);
			w[i] = rng;
		end
		g = {w[3][3:0], w[2], w[1], w[0]};	// 100 bits
	endtask

	task automatic set_row(int r, grid_bits_t blk, grid_bits_t lo, grid_bits_t hi,
		tile_idx_t a, tile_idx_t b, tile_idx_t c, tile_idx_t d,
		game_state_t g, int e1, int e2);
		t_block[r] = blk;
		t_lo[r] = lo;
		t_hi[r] = hi;
		{t_p1r[r], t_p1c[r], t_p2r[r], t_p2c[r]} = {a, b, c, d};
		t_game[r] = g;
		t_exp1[r] = e1;
		t_exp2[r] = e2;
	endtask

	task automatic build_table();
		grid_bits_t rb, rl, rh;
		// blocks, three bomb stages, a bomb bit under a block
		set_row(0, grid_bit(0, 0) | grid_bit(4, 5) | grid_bit(9, 9),
			grid_bit(1, 1) | grid_bit(1, 3) | grid_bit(0, 0),
			grid_bit(1, 2) | grid_bit(1, 3),
			4'd2, 4'd3, 4'd7, 4'd7, GAME_ON, 1024, 1024);
		// both players in one block cell, player 1 on top
		set_row(1, grid_bit(5, 5) | grid_bit(3, 3), grid_bit(3, 4),
			grid_bit(3, 4) | grid_bit(6, 2),
			4'd5, 4'd5, 4'd5, 4'd5, GAME_ON, 1024, 0);
		set_row(2, grid_bit(0, 9) | grid_bit(9, 0), '0, '0,
			4'd0, 4'd9, 4'd9, 4'd0, P1_WINS, 1024, 0);
		set_row(3, grid_bit(0, 9) | grid_bit(9, 0), '0, '0,
			4'd0, 4'd9, 4'd9, 4'd0, P2_WINS, 0, 1024);
		random_grid(rb);
		random_grid(rl);
		random_grid(rh);
		set_row(4, rb, rl, rh, 4'd8, 4'd1, 4'd1, 4'd8, DRAW, 1024, 1024);
	endtask

	task automatic apply_row(int r);
		block = t_block[r];
		bomb_lo = t_lo[r];
		bomb_hi = t_hi[r];
		{p1_row, p1_col, p2_row, p2_col} = {t_p1r[r], t_p1c[r], t_p2r[r], t_p2c[r]};
		game = t_game[r];
		exp_p1 = t_exp1[r];
		exp_p2 = t_exp2[r];
	endtask

	// run limit from the number of frames in the table
	always @(posedge pixel_clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout after %0d cycles, frames checked %0d", cycles, frames);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		pixel_clk = 1'b0;
		rst = 1'b1;
		cycles = 0;
		rng = 32'h6a70_720e;
		{block, bomb_lo, bomb_hi} = '0;
		{p1_row, p1_col, p2_row, p2_col} = '0;
		game = GAME_ON;
		exp_p1 = 0;
		exp_p2 = 0;
		build_table();
		repeat (5) @(posedge pixel_clk);
		#1 rst = 1'b0;
		for (int r = 0; r < N_ROWS; r++) begin
			@(negedge vsync);	// new frame, checker closes the last one
			@(posedge pixel_clk);
			#1 apply_row(r);	// still inside the vsync pulse
		end
		@(negedge vsync);	// last row gets its count check here
		repeat (10) @(posedge pixel_clk);
		if (frames != N_ROWS)
			$display("only %0d of %0d frames were checked", frames, N_ROWS);
		$display("pixels %0d, frames %0d, errors %0d", pixels, frames, errors);
		if ((errors == 0) && (frames == N_ROWS))
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tb_checker.sv
/*
 * testbench checker for the arena renderer
 * rebuilds pixel position from the sync edges, reference picture
 * per-pixel rgb compare, sync widths, player pixel counts per frame
 */

`timescale 1ns/1ps

module tb_checker
	import vga_pkg::*;
#(
	parameter int H_TOTAL = 800,
	parameter int H_SYNC  = 96,
	parameter int H_START = 144,
	parameter int V_SYNC  = 2,
	parameter int V_START = 31
) (
	input  logic        pixel_clk,
	input  logic        rst,
	input  grid_bits_t  block_i,
	input  grid_bits_t  bomb_lo_i,
	input  grid_bits_t  bomb_hi_i,
	input  tile_idx_t   p1_row_i,
	input  tile_idx_t   p1_col_i,
	input  tile_idx_t   p2_row_i,
	input  tile_idx_t   p2_col_i,
	input  game_state_t game_i,
	input  logic        hsync_i,
	input  logic        vsync_i,
	input  rgb_t        rgb_i,
	input  int          exp_p1_i,	// expected player 1 pixels in the frame
	input  int          exp_p2_i,
	output int          errors_o,
	output int          frames_o,	// frames whose counts were compared
	output int          pixels_o
);

	localparam int MAX_PRINT = 20;	// error lines shown, all are counted

	logic prev_h, prev_v, h_fall, v_fall, h_rise, v_rise;
	logic synced, h_seen, v_seen;	// sync edges seen since reset
	int hcnt, vcnt;	// position from the last sync falls
	int h_low, v_low;	// length of the current sync pulse
	int n_p1, n_p2;
	logic [7:0] exp_rgb;

	// brick joints, columns 0 13 26 39 52 63 and rows 0 9 19 29 39 47
	function automatic logic on_joint(tile_px_t lx, tile_px_t ly);
		logic col_hit, row_hit;
		col_hit = (lx == 6'd0) || (lx == 6'd13) || (lx == 6'd26) ||
			(lx == 6'd39) || (lx == 6'd52) || (lx == 6'd63);
		row_hit = (ly == 6'd0) || (ly == 6'd9) || (ly == 6'd19) ||
			(ly == 6'd29) || (ly == 6'd39) || (ly == 6'd47);
		return col_hit || row_hit;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference picture, r3 g3 b2
	//////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] ref_pixel(int x, int y);
		tile_idx_t row, col;
		tile_px_t lx, ly;
		logic [6:0] idx;
		logic in_sq, p1, p2;
		logic [1:0] stage;
		if ((x < 0) || (x >= GRID_N * TILE_W) || (y < 0) || (y >= GRID_N * TILE_H))
			return 8'h00;	// porch and sync are black
		col = tile_idx_t'(x / TILE_W);
		row = tile_idx_t'(y / TILE_H);
		lx = tile_px_t'(x % TILE_W);
		ly = tile_px_t'(y % TILE_H);
		idx = 7'((y / TILE_H) * GRID_N + x / TILE_W);
		in_sq = (lx >= 6'd16) && (lx <= 6'd47) && (ly >= 6'd8) && (ly <= 6'd39);
		p1 = (game_i != P2_WINS) && (row == p1_row_i) && (col == p1_col_i);
		p2 = (game_i != P1_WINS) && (row == p2_row_i) && (col == p2_col_i);
		if (p1)
			return in_sq ? 8'h1C : 8'hFF;	// green square on white
		if (p2)
			return in_sq ? 8'h03 : 8'hFF;	// blue square
		if (block_i[idx])
			return on_joint(lx, ly) ? 8'h00 : 8'hC8;
		stage = {bomb_hi_i[idx], bomb_lo_i[idx]};
		case (stage)
			2'd1:    return 8'hA7;
			2'd2:    return 8'h83;
			2'd3:    return 8'hE0;
			default: return 8'hFF;	// floor
		endcase
	endfunction

	task automatic flag_error(string what, int want, int got);
		errors_o++;
		if (errors_o <= MAX_PRINT)
			$display("Error: %s at x=%0d y=%0d expected %h got %h", what,
				hcnt - H_START, vcnt - V_START, want, got);
	endtask

	// sample on the falling edge, away from the DUT's register updates
	always @(negedge pixel_clk) begin
		if (rst) begin
			{prev_h, prev_v, synced, h_seen, v_seen} = '0;
			{hcnt, vcnt, h_low, v_low, n_p1, n_p2} = '0;
			{errors_o, frames_o, pixels_o} = '0;
		end else begin
			h_fall = prev_h && !hsync_i;
			v_fall = prev_v && !vsync_i;
			h_rise = !prev_h && hsync_i;
			v_rise = !prev_v && vsync_i;
			if (h_fall) begin
				hcnt = 0;
				vcnt = v_fall ? 0 : vcnt + 1;
			end else begin
				hcnt++;
			end
			if (v_fall) begin	// frame boundary
				if (synced) begin
					if (n_p1 != exp_p1_i)
						flag_error("rgb_o p1 pixel count", exp_p1_i, n_p1);
					if (n_p2 != exp_p2_i)
						flag_error("rgb_o p2 pixel count", exp_p2_i, n_p2);
					frames_o++;
				end
				synced = 1'b1;
				n_p1 = 0;
				n_p2 = 0;
			end
			// pulse widths, 96 pixels and 2 lines
			if (h_rise && h_seen && (h_low != H_SYNC))
				flag_error("hsync_o low width", H_SYNC, h_low);
			if (v_rise && v_seen && (v_low != V_SYNC * H_TOTAL))
				flag_error("vsync_o low width", V_SYNC * H_TOTAL, v_low);
			h_seen = h_seen || h_fall;
			v_seen = v_seen || v_fall;
			h_low = h_fall ? 1 : (hsync_i ? 0 : h_low + 1);
			v_low = v_fall ? 1 : (vsync_i ? 0 : v_low + 1);
			if (synced) begin
				exp_rgb = ref_pixel(hcnt - H_START, vcnt - V_START);
				if (rgb_i != exp_rgb)
					flag_error("rgb_o", exp_rgb, rgb_i);
				if (rgb_i == 8'h1C)
					n_p1++;
				if (rgb_i == 8'h03)
					n_p2++;
				pixels_o++;
			end
			prev_h = hsync_i;
			prev_v = vsync_i;
		end
	end

endmodule

// File: arena_display.sv
/*
 * top level of the arena renderer
 * raster timing, tile and sprite layers, output mux
 */

`timescale 1ns/1ps

module arena_display
	import vga_pkg::*;
#(
	parameter int H_TOTAL = 800,	// pixels per line
	parameter int H_SYNC  = 96,
	parameter int H_START = 144,	// sync plus back porch
	parameter int V_TOTAL = 521,	// lines per frame
	parameter int V_SYNC  = 2,
	parameter int V_START = 31
) (
	input  logic        pixel_clk,
	input  logic        rst,
	input  grid_bits_t  block_i,
	input  grid_bits_t  bomb_lo_i,
	input  grid_bits_t  bomb_hi_i,
	input  tile_idx_t   p1_row_i,
	input  tile_idx_t   p1_col_i,
	input  tile_idx_t   p2_row_i,
	input  tile_idx_t   p2_col_i,
	input  game_state_t game_i,
	output logic        hsync_o,
	output logic        vsync_o,
	output rgb_t        rgb_o
);

	tile_idx_t tile_row, tile_col;
	tile_px_t  local_x, local_y;
	logic      active, hsync_raw, vsync_raw;	// timing outputs, not yet aligned
	color_code_t tile_code, sprite_code;
	logic      sprite_hit;

	vga_timing #(
		.H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC), .H_START(H_START),
		.V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .V_START(V_START)
	) u_timing (
		.pixel_clk(pixel_clk), .rst(rst),
		.tile_row_o(tile_row), .tile_col_o(tile_col),
		.local_x_o(local_x), .local_y_o(local_y),
		.active_o(active), .hsync_o(hsync_raw), .vsync_o(vsync_raw)
	);

	tile_layer u_tiles (
		.pixel_clk(pixel_clk), .rst(rst),
		.tile_row_i(tile_row), .tile_col_i(tile_col),
		.local_x_i(local_x), .local_y_i(local_y),
		.block_i(block_i), .bomb_lo_i(bomb_lo_i), .bomb_hi_i(bomb_hi_i),
		.tile_code_o(tile_code)
	);

	sprite_layer u_sprites (
		.pixel_clk(pixel_clk), .rst(rst),
		.tile_row_i(tile_row), .tile_col_i(tile_col),
		.local_x_i(local_x), .local_y_i(local_y),
		.p1_row_i(p1_row_i), .p1_col_i(p1_col_i),
		.p2_row_i(p2_row_i), .p2_col_i(p2_col_i),
		.game_i(game_i),
		.sprite_hit_o(sprite_hit), .sprite_code_o(sprite_code)
	);

	pixel_mux u_mux (
		.pixel_clk(pixel_clk), .rst(rst),
		.active_i(active), .hsync_i(hsync_raw), .vsync_i(vsync_raw),
		.tile_code_i(tile_code), .sprite_code_i(sprite_code),
		.sprite_hit_i(sprite_hit),
		.rgb_o(rgb_o), .hsync_o(hsync_o), .vsync_o(vsync_o)
	);

endmodule

// File: pixel_mux.sv
/*
 * output stage
 * sync and active alignment with the layer codes
 * layer select, palette lookup, blanking, registered rgb and sync
 */

`timescale 1ns/1ps

module pixel_mux
	import vga_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        rst,
	input  logic        active_i,
	input  logic        hsync_i,
	input  logic        vsync_i,
	input  color_code_t tile_code_i,
	input  color_code_t sprite_code_i,
	input  logic        sprite_hit_i,
	output rgb_t        rgb_o,
	output logic        hsync_o,
	output logic        vsync_o
);

	logic active_d, hsync_d, vsync_d;	// flags one cycle late, level with layer codes
	color_code_t code_sel;

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			active_d <= 1'b0;
			hsync_d  <= 1'b0;
			vsync_d  <= 1'b0;
		end else begin
			active_d <= active_i;
			hsync_d  <= hsync_i;
			vsync_d  <= vsync_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// layer select and colour
	//////////////////////////////////////////////////////////////////////

	assign code_sel = sprite_hit_i ? sprite_code_i : tile_code_i;

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			rgb_o   <= '0;
			hsync_o <= 1'b0;
			vsync_o <= 1'b0;
		end else begin
			rgb_o   <= active_d ? palette(code_sel) : '0;	// black in the porches
			hsync_o <= hsync_d;
			vsync_o <= vsync_d;
		end
	end

	// both sync pulses lie in the blanking, no colour while either is low
	assert property (@(posedge pixel_clk) disable iff (rst)
		!(hsync_o && vsync_o) |-> (rgb_o == '0));

endmodule

// File: sprite_layer.sv
/*
 * player layer
 * 32x32 square per player in its cell, player 1 on top
 * game over hides the losing player
 */

`timescale 1ns/1ps

module sprite_layer
	import vga_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        rst,
	input  tile_idx_t   tile_row_i,
	input  tile_idx_t   tile_col_i,
	input  tile_px_t    local_x_i,
	input  tile_px_t    local_y_i,
	input  tile_idx_t   p1_row_i,
	input  tile_idx_t   p1_col_i,
	input  tile_idx_t   p2_row_i,
	input  tile_idx_t   p2_col_i,
	input  game_state_t game_i,
	output logic        sprite_hit_o,
	output color_code_t sprite_code_o
);

	logic p1_show, p2_show;	// not blanked by game over
	logic p1_cell, p2_cell;	// current tile is the player's cell
	logic hit1, hit2;
	logic in_sq;	// pixel lies inside the square
	color_code_t code_nxt;

	assign p1_show = (game_i != P2_WINS);
	assign p2_show = (game_i != P1_WINS);

	assign p1_cell = (tile_row_i == p1_row_i) && (tile_col_i == p1_col_i);
	assign p2_cell = (tile_row_i == p2_row_i) && (tile_col_i == p2_col_i);

	assign hit1 = p1_show && p1_cell;
	assign hit2 = p2_show && p2_cell;

	assign in_sq = (local_x_i >= SPRITE_X0) && (local_x_i <= SPRITE_X1) &&
		(local_y_i >= SPRITE_Y0) && (local_y_i <= SPRITE_Y1);

	always_comb begin
		if (hit1)
			code_nxt = in_sq ? CC_P1 : CC_BG;	// p1 wins a shared cell
		else if (hit2)
			code_nxt = in_sq ? CC_P2 : CC_BG;
		else
			code_nxt = CC_NONE;
	end

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			sprite_hit_o  <= 1'b0;
			sprite_code_o <= CC_NONE;
		end else begin
			sprite_hit_o  <= hit1 || hit2;	// whole cell covers the tile layer
			sprite_code_o <= code_nxt;
		end
	end

	// game logic must keep players on the arena
	assert property (@(posedge pixel_clk) disable iff (rst)
		(p1_row_i < tile_idx_t'(GRID_N)) && (p1_col_i < tile_idx_t'(GRID_N)) &&
		(p2_row_i < tile_idx_t'(GRID_N)) && (p2_col_i < tile_idx_t'(GRID_N)));

endmodule

// File: tile_layer.sv
/*
 * background layer of the arena
 * block tiles with mortar lines, three bomb stages, empty floor
 */

`timescale 1ns/1ps

module tile_layer
	import vga_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        rst,
	input  tile_idx_t   tile_row_i,
	input  tile_idx_t   tile_col_i,
	input  tile_px_t    local_x_i,
	input  tile_px_t    local_y_i,
	input  grid_bits_t  block_i,
	input  grid_bits_t  bomb_lo_i,
	input  grid_bits_t  bomb_hi_i,
	output color_code_t tile_code_o
);

	localparam int IDX_W = $clog2(GRID_N * GRID_N);

	logic [IDX_W-1:0] idx;	// row major tile index
	logic [1:0] stage;	// bomb stage of this tile
	logic blk;
	color_code_t code_nxt;

	assign idx   = IDX_W'(tile_row_i) * IDX_W'(GRID_N) + IDX_W'(tile_col_i);
	assign blk   = block_i[idx];
	assign stage = {bomb_hi_i[idx], bomb_lo_i[idx]};

	//////////////////////////////////////////////////////////////////////
	// tile colour
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (blk) begin
			// bricks with black joints
			code_nxt = is_mortar(local_x_i, local_y_i) ? CC_MORTAR : CC_BRICK;
		end else begin
			case (stage)
				2'd1:    code_nxt = CC_BOMB1;
				2'd2:    code_nxt = CC_BOMB2;
				2'd3:    code_nxt = CC_BOMB3;
				default: code_nxt = CC_BG;	// plain floor
			endcase
		end
	end

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst)
			tile_code_o <= CC_BG;
		else
			tile_code_o <= code_nxt;
	end

endmodule

// File: vga_timing.sv
/*
 * 640x480 raster timing
 * line and frame counters, nested tile counters in the active window
 * registered tile position, active flag, hsync and vsync
 */

`timescale 1ns/1ps

module vga_timing
	import vga_pkg::*;
#(
	parameter int H_TOTAL = 800,
	parameter int H_SYNC  = 96,
	parameter int H_START = 144,
	parameter int V_TOTAL = 521,
	parameter int V_SYNC  = 2,
	parameter int V_START = 31
) (
	input  logic      pixel_clk,
	input  logic      rst,
	output tile_idx_t tile_row_o,
	output tile_idx_t tile_col_o,
	output tile_px_t  local_x_o,
	output tile_px_t  local_y_o,
	output logic      active_o,
	output logic      hsync_o,
	output logic      vsync_o
);

	localparam int HC_W = $clog2(H_TOTAL);
	localparam int VC_W = $clog2(V_TOTAL);

	localparam logic [HC_W-1:0] H_LAST    = HC_W'(H_TOTAL - 1);
	localparam logic [HC_W-1:0] H_SYNC_E  = HC_W'(H_SYNC);
	localparam logic [HC_W-1:0] H_ACT_BEG = HC_W'(H_START);
	localparam logic [HC_W-1:0] H_ACT_END = HC_W'(H_START + GRID_N * TILE_W);	// half open
	localparam logic [VC_W-1:0] V_LAST    = VC_W'(V_TOTAL - 1);
	localparam logic [VC_W-1:0] V_SYNC_E  = VC_W'(V_SYNC);
	localparam logic [VC_W-1:0] V_ACT_BEG = VC_W'(V_START);
	localparam logic [VC_W-1:0] V_ACT_END = VC_W'(V_START + GRID_N * TILE_H);

	localparam tile_px_t  LX_LAST = tile_px_t'(TILE_W - 1);
	localparam tile_px_t  LY_LAST = tile_px_t'(TILE_H - 1);
	localparam tile_idx_t T_LAST  = tile_idx_t'(GRID_N - 1);

	logic [HC_W-1:0] hc;	// pixel in line
	logic [VC_W-1:0] vc;	// line in frame
	tile_px_t  lx, ly;	// position inside the tile
	tile_idx_t tc, tr;	// tile column and row
	logic h_act, v_act, line_end;

	assign h_act    = (hc >= H_ACT_BEG) && (hc < H_ACT_END);
	assign v_act    = (vc >= V_ACT_BEG) && (vc < V_ACT_END);
	assign line_end = (hc == H_LAST);

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			hc <= '0;
			vc <= '0;
		end else if (line_end) begin
			hc <= '0;
			vc <= (vc == V_LAST) ? '0 : vc + 1'b1;	// wrap at frame end
		end else begin
			hc <= hc + 1'b1;
		end
	end

	// tile counters step only inside the window
	// 10 tiles fill the window exactly so they come back to 0 on their own
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			lx <= '0;
			tc <= '0;
			ly <= '0;
			tr <= '0;
		end else begin
			if (h_act) begin
				if (lx == LX_LAST) begin
					lx <= '0;
					tc <= (tc == T_LAST) ? '0 : tc + 1'b1;
				end else begin
					lx <= lx + 1'b1;
				end
			end
			if (v_act && line_end) begin	// one step per active line
				if (ly == LY_LAST) begin
					ly <= '0;
					tr <= (tr == T_LAST) ? '0 : tr + 1'b1;
				end else begin
					ly <= ly + 1'b1;
				end
			end
		end
	end

	// output stage, one cycle behind the counters
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			tile_row_o <= '0;
			tile_col_o <= '0;
			local_x_o  <= '0;
			local_y_o  <= '0;
			active_o   <= 1'b0;
			hsync_o    <= 1'b0;
			vsync_o    <= 1'b0;
		end else begin
			tile_row_o <= tr;
			tile_col_o <= tc;
			local_x_o  <= lx;
			local_y_o  <= ly;
			active_o   <= h_act && v_act;
			hsync_o    <= (hc >= H_SYNC_E);	// low for the first H_SYNC pixels
			vsync_o    <= (vc >= V_SYNC_E);
		end
	end

	// tile position is back at the arena corner whenever the raster leaves the window
	assert property (@(posedge pixel_clk) disable iff (rst)
		!h_act |-> (lx == '0) && (tc == '0));
	assert property (@(posedge pixel_clk) disable iff (rst)
		!v_act |-> (ly == '0) && (tr == '0));

endmodule

// File: vga_pkg.sv
/*
 * shared definitions for the arena renderer
 * grid geometry, tile index and pixel types, game state
 * colour codes, 8-bit rgb type, sprite box, mortar lines, palette
 */

package vga_pkg;

	//////////////////////////////////////////////////////////////////////
	// arena geometry
	//////////////////////////////////////////////////////////////////////

	localparam integer GRID_N = 10;	// tiles per side
	localparam integer TILE_W = 64;	// 640 / 10
	localparam integer TILE_H = 48;	// 480 / 10

	typedef logic [3:0] tile_idx_t;	// tile row or column
	typedef logic [5:0] tile_px_t;	// pixel inside a tile, 0..63
	typedef logic [GRID_N*GRID_N-1:0] grid_bits_t;	// row*10 + col

	typedef enum logic [1:0] {
		GAME_ON = 2'd0,
		P1_WINS = 2'd1,	// player 2 hidden
		P2_WINS = 2'd2,	// player 1 hidden
		DRAW    = 2'd3	// both shown
	} game_state_t;

	typedef enum logic [3:0] {
		CC_BG, CC_BRICK, CC_MORTAR,
		CC_BOMB1, CC_BOMB2, CC_BOMB3,
		CC_P1, CC_P2,
		CC_NONE	// no sprite on this pixel
	} color_code_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_t;

	// player square inside its cell, inclusive bounds
	localparam tile_px_t SPRITE_X0 = 6'd16;
	localparam tile_px_t SPRITE_X1 = 6'd47;
	localparam tile_px_t SPRITE_Y0 = 6'd8;
	localparam tile_px_t SPRITE_Y1 = 6'd39;

	// brick pattern, local columns and rows drawn as mortar
	localparam integer MORTAR_N = 6;
	localparam tile_px_t MORTAR_COLS [MORTAR_N] = '{6'd0, 6'd13, 6'd26, 6'd39, 6'd52, 6'd63};
	localparam tile_px_t MORTAR_ROWS [MORTAR_N] = '{6'd0, 6'd9, 6'd19, 6'd29, 6'd39, 6'd47};

	function automatic logic is_mortar(tile_px_t x, tile_px_t y);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < MORTAR_N; i++) begin
			if ((x == MORTAR_COLS[i]) || (y == MORTAR_ROWS[i]))
				hit = 1'b1;
		end
		return hit;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// colour code to rgb
	//////////////////////////////////////////////////////////////////////

	function automatic rgb_t palette(color_code_t code);
		rgb_t c;
		case (code)
			CC_BG:     c = '{3'b111, 3'b111, 2'b11};	// white
			CC_BRICK:  c = '{3'b110, 3'b010, 2'b00};
			CC_MORTAR: c = '{3'b000, 3'b000, 2'b00};	// black
			CC_BOMB1:  c = '{3'b101, 3'b001, 2'b11};
			CC_BOMB2:  c = '{3'b100, 3'b000, 2'b11};
			CC_BOMB3:  c = '{3'b111, 3'b000, 2'b00};	// about to blow
			CC_P1:     c = '{3'b000, 3'b111, 2'b00};	// green
			CC_P2:     c = '{3'b000, 3'b000, 2'b11};	// blue
			default:   c = '0;
		endcase
		return c;
	endfunction

endpackage
